// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ##############################
    // Instruction field layout
    // ##############################
    localparam int INSTR_W    = 32;        // Instruction word width.
    localparam int REG_ADDR_W = 5;         // Register address width.

    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 28;
    localparam int FUNCT_MSB  = 27;
    localparam int FUNCT_LSB  = 25;
    localparam int RD_MSB     = 24;        // Also the store data register.
    localparam int RD_LSB     = 20;
    localparam int RS1_MSB    = 19;
    localparam int RS1_LSB    = 15;
    localparam int RS2_MSB    = 14;
    localparam int RS2_LSB    = 10;
    localparam int IMM_MSB    = 14;        // Immediate overlaps rs2.
    localparam int IMM_LSB    = 0;
    localparam int IMM_W      = IMM_MSB - IMM_LSB + 1;

    // ##############################
    // Opcodes and ALU operations
    // ##############################
    // Codes outside this list decode as a no-operation.
    typedef enum logic [3:0] {
        OP_ALU  = 4'h1,                    // Register-register op picked by funct.
        OP_ADDI = 4'h2,
        OP_LD   = 4'h3,
        OP_SD   = 4'h4
    } opcode_t;

    // Funct field of OP_ALU maps straight onto this encoding.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    // ##############################
    // Control bundle
    // ##############################
    typedef struct packed {
        alu_op_t                alu_op;
        logic                   use_imm;     // ALU B takes the immediate.
        logic                   mem_to_reg;  // Write-back takes memory data.
        logic                   reg_write;
        logic                   mem_write;
        logic [REG_ADDR_W-1:0]  rd;
    } ctrl_t;

endpackage

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit #(
    parameter int WORDSIZE = 64            // Datapath width.
) (
    input  wire [cpu_pkg::INSTR_W-1:0]    instr,
    output cpu_pkg::ctrl_t                ctrl,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs1,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_sel,
    output logic [WORDSIZE-1:0]           imm
);
    import cpu_pkg::*;

    opcode_t                opcode;
    logic [2:0]             funct;
    logic [REG_ADDR_W-1:0]  rd_field;
    logic [REG_ADDR_W-1:0]  rs2_field;
    logic [IMM_W-1:0]       imm_field;

    // ##############################
    // Field extraction
    // ##############################
    assign opcode    = opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);
    assign funct     = instr[FUNCT_MSB:FUNCT_LSB];
    assign rd_field  = instr[RD_MSB:RD_LSB];
    assign rs1       = instr[RS1_MSB:RS1_LSB];
    assign rs2_field = instr[RS2_MSB:RS2_LSB];
    assign imm_field = instr[IMM_MSB:IMM_LSB];

    // Sign extension of the 15-bit immediate.
    assign imm = {{(WORDSIZE-IMM_W){imm_field[IMM_W-1]}}, imm_field};

    // ##############################
    // Decode
    // ##############################
    always_comb begin
        ctrl         = '0;                 // No-operation unless decoded below.
        ctrl.alu_op  = ALU_ADD;
        ctrl.rd      = rd_field;
        rs2_sel      = rs2_field;

        case (opcode)
            OP_ALU: begin
                // Funct values 6 and 7 are unused and write nothing.
                if (funct <= ALU_SLT) begin
                    ctrl.alu_op    = alu_op_t'(funct);
                    ctrl.reg_write = 1'b1;
                end
            end
            OP_ADDI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LD: begin
                ctrl.use_imm    = 1'b1;    // Address is base plus offset.
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            OP_SD: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                rs2_sel        = rd_field; // Store data comes out of port B.
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file #(
    parameter int WORDSIZE = 64
) (
    input  wire                           cpu_clk,
    input  wire                           rst,
    input  wire [cpu_pkg::REG_ADDR_W-1:0] addr_a,
    input  wire [cpu_pkg::REG_ADDR_W-1:0] addr_b,
    input  wire                           write_en,
    input  wire [cpu_pkg::REG_ADDR_W-1:0] write_addr,
    input  wire [WORDSIZE-1:0]            write_data,
    output logic [WORDSIZE-1:0]           data_a,
    output logic [WORDSIZE-1:0]           data_b
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [WORDSIZE-1:0] regs [NUM_REGS];

    always_ff @(posedge cpu_clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_addr != '0)) begin
            regs[write_addr] <= write_data;    // Register 0 never written.
        end
    end

    // Combinational reads with register 0 forced to zero.
    assign data_a = (addr_a == '0) ? '0 : regs[addr_a];
    assign data_b = (addr_b == '0) ? '0 : regs[addr_b];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int WORDSIZE = 64
) (
    input  wire [WORDSIZE-1:0]     input_a,
    input  wire [WORDSIZE-1:0]     input_b,
    input  wire cpu_pkg::alu_op_t  operation,
    output logic [WORDSIZE-1:0]    result,
    output logic                   overflow
);
    import cpu_pkg::*;

    localparam int MSB = WORDSIZE - 1;

    logic [WORDSIZE-1:0] sum;
    logic [WORDSIZE-1:0] diff;
    logic                add_ovf;
    logic                sub_ovf;
    logic                less;

    assign sum  = input_a + input_b;
    assign diff = input_a - input_b;

    // Same-sign operands giving a result of the other sign.
    assign add_ovf = (input_a[MSB] == input_b[MSB]) && (sum[MSB] != input_a[MSB]);
    // Operands of different sign with the result sign flipping away from A.
    assign sub_ovf = (input_a[MSB] != input_b[MSB]) && (diff[MSB] != input_a[MSB]);

    assign less = $signed(input_a) < $signed(input_b);

    always_comb begin
        overflow = 1'b0;                   // Only add and sub can overflow.
        case (operation)
            ALU_ADD: begin
                result   = sum;
                overflow = add_ovf;
            end
            ALU_SUB: begin
                result   = diff;
                overflow = sub_ovf;
            end
            ALU_AND: result = input_a & input_b;
            ALU_OR:  result = input_a | input_b;
            ALU_XOR: result = input_a ^ input_b;
            ALU_SLT: result = {{(WORDSIZE-1){1'b0}}, less};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int WORDSIZE = 64,
    parameter int SIZE     = 512           // Depth in doublewords.
) (
    input  wire                 cpu_clk,
    input  wire [WORDSIZE-1:0]  addr,      // Byte address.
    input  wire [WORDSIZE-1:0]  data_input,
    input  wire                 write_en,
    output logic [WORDSIZE-1:0] data_output
);
    localparam int BYTE_OFFSET = $clog2(WORDSIZE / 8);
    localparam int IDX_W       = (SIZE > 1) ? $clog2(SIZE) : 1;

    logic [WORDSIZE-1:0]             mem [SIZE];
    logic [WORDSIZE-BYTE_OFFSET-1:0] word_addr;
    logic [IDX_W-1:0]                index;

    // Word address wraps modulo the depth.
    assign word_addr = addr[WORDSIZE-1:BYTE_OFFSET];
    assign index     = IDX_W'(word_addr % SIZE);

    always_ff @(posedge cpu_clk) begin
        if (write_en) begin
            mem[index] <= data_input;
        end
    end

    assign data_output = mem[index];       // Asynchronous read.

endmodule

`default_nettype wire

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter int WORDSIZE = 64,           // Datapath width.
    parameter int SIZE     = 512           // Data memory depth in words.
) (
    input  wire                            cpu_clk,
    input  wire                            rst,
    input  wire [cpu_pkg::INSTR_W-1:0]     instr,
    input  wire                            instr_valid,
    output logic                           retire_valid,
    output logic [cpu_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [WORDSIZE-1:0]            retire_data,
    output logic                           retire_overflow,
    output logic                           retire_store
);
    import cpu_pkg::*;

    // Control unit outputs.
    ctrl_t                  cu_ctrl;
    logic [REG_ADDR_W-1:0]  cu_rs1;
    logic [REG_ADDR_W-1:0]  cu_rs2_sel;
    logic [WORDSIZE-1:0]    cu_imm;

    // Register file.
    logic                   rf_write_en;
    logic [WORDSIZE-1:0]    rf_data_a;
    logic [WORDSIZE-1:0]    rf_data_b;

    // ALU.
    logic [WORDSIZE-1:0]    alu_input_b;
    logic [WORDSIZE-1:0]    alu_result;
    logic                   alu_overflow;

    // Data memory and write-back.
    logic                   dm_write_en;
    logic [WORDSIZE-1:0]    dm_data_output;
    logic [WORDSIZE-1:0]    wb_data;

    // ##############################
    // Blocks
    // ##############################
    control_unit #(.WORDSIZE(WORDSIZE)) cu_inst (
        .instr   (instr),
        .ctrl    (cu_ctrl),
        .rs1     (cu_rs1),
        .rs2_sel (cu_rs2_sel),
        .imm     (cu_imm)
    );

    register_file #(.WORDSIZE(WORDSIZE)) rf_inst (
        .cpu_clk    (cpu_clk),
        .rst        (rst),
        .addr_a     (cu_rs1),
        .addr_b     (cu_rs2_sel),
        .write_en   (rf_write_en),
        .write_addr (cu_ctrl.rd),
        .write_data (wb_data),
        .data_a     (rf_data_a),
        .data_b     (rf_data_b)
    );

    alu #(.WORDSIZE(WORDSIZE)) alu_inst (
        .input_a   (rf_data_a),
        .input_b   (alu_input_b),
        .operation (cu_ctrl.alu_op),
        .result    (alu_result),
        .overflow  (alu_overflow)
    );

    data_memory #(.WORDSIZE(WORDSIZE), .SIZE(SIZE)) dm_inst (
        .cpu_clk     (cpu_clk),
        .addr        (alu_result),          // Byte address from the ALU.
        .data_input  (rf_data_b),
        .write_en    (dm_write_en),
        .data_output (dm_data_output)
    );

    // ##############################
    // Selections and write enables
    // ##############################
    assign alu_input_b = cu_ctrl.use_imm ? cu_imm : rf_data_b;
    assign wb_data     = cu_ctrl.mem_to_reg ? dm_data_output : alu_result;

    // Nothing is written unless the strobe is up.
    assign rf_write_en = cu_ctrl.reg_write && instr_valid;
    assign dm_write_en = cu_ctrl.mem_write && instr_valid;

    // ##############################
    // Retire report
    // ##############################
    always_ff @(posedge cpu_clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_store <= 1'b0;
        end else begin
            retire_valid <= instr_valid && !cu_ctrl.mem_write;  // Stores report separately.
            retire_store <= instr_valid && cu_ctrl.mem_write;
        end
    end

    // Payload is held low between instructions.
    always_ff @(posedge cpu_clk) begin
        if (instr_valid) begin
            retire_rd       <= cu_ctrl.rd;
            retire_data     <= wb_data;
            retire_overflow <= alu_overflow;
        end else begin
            retire_rd       <= '0;
            retire_data     <= '0;
            retire_overflow <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int WORDSIZE       = 64;
    localparam int SIZE           = 512;
    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;     // Inputs change this long after the edge.
    localparam int TIMEOUT_CYCLES = 20;

    // One table row holds the stimulus and what the retire ports should show.
    typedef struct packed {
        logic [INSTR_W-1:0]    instr;
        logic                  valid;
        logic                  exp_valid;
        logic                  exp_store;
        logic [REG_ADDR_W-1:0] exp_rd;
        logic [WORDSIZE-1:0]   exp_data;
        logic                  exp_ovf;
    } step_t;

    logic                  cpu_clk;
    logic                  rst;
    logic [INSTR_W-1:0]    instr;
    logic                  instr_valid;
    logic                  retire_valid;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [WORDSIZE-1:0]   retire_data;
    logic                  retire_overflow;
    logic                  retire_store;

    step_t steps [$];
    int    pass_count;
    int    fail_count;
    bit    timed_out;

    cpu #(.WORDSIZE(WORDSIZE), .SIZE(SIZE)) cpu_i (
        .cpu_clk         (cpu_clk),
        .rst             (rst),
        .instr           (instr),
        .instr_valid     (instr_valid),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_data     (retire_data),
        .retire_overflow (retire_overflow),
        .retire_store    (retire_store)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
    end

    // ##############################
    // Instruction encoding
    // ##############################
    function automatic logic [INSTR_W-1:0] encode_alu(alu_op_t op, int rd, int rs1, int rs2);
        return {OP_ALU, op, 5'(rd), 5'(rs1), 5'(rs2), 10'd0};
    endfunction

    function automatic logic [INSTR_W-1:0] encode_imm(opcode_t op, int rd, int rs1, int imm);
        return {op, 3'd0, 5'(rd), 5'(rs1), 15'(imm)};
    endfunction

    // ##############################
    // Table construction
    // ##############################
    function automatic void push_row(logic [INSTR_W-1:0] word, logic valid, logic exp_valid,
                                     logic exp_store, int rd, logic [WORDSIZE-1:0] data,
                                     logic ovf);
        step_t s;
        s.instr     = word;
        s.valid     = valid;
        s.exp_valid = exp_valid;
        s.exp_store = exp_store;
        s.exp_rd    = 5'(rd);
        s.exp_data  = data;
        s.exp_ovf   = ovf;
        steps.push_back(s);
    endfunction

    function automatic void expect_write(logic [INSTR_W-1:0] word, int rd,
                                         logic [WORDSIZE-1:0] data, logic ovf);
        push_row(word, 1'b1, 1'b1, 1'b0, rd, data, ovf);
    endfunction

    function automatic void expect_store(logic [INSTR_W-1:0] word);
        push_row(word, 1'b1, 1'b0, 1'b1, 0, '0, 1'b0);
    endfunction

    function automatic void expect_idle(logic [INSTR_W-1:0] word);
        push_row(word, 1'b0, 1'b0, 1'b0, 0, '0, 1'b0);
    endfunction

    function automatic void build_table();
        // Immediates with x3 negative.
        expect_write(encode_imm(OP_ADDI, 1, 0, 5), 1, 64'd5, 1'b0);
        expect_write(encode_imm(OP_ADDI, 2, 0, 3), 2, 64'd3, 1'b0);
        expect_write(encode_imm(OP_ADDI, 3, 0, -2), 3, 64'hffff_ffff_ffff_fffe, 1'b0);
        expect_write(encode_imm(OP_ADDI, 4, 0, 'h3fff), 4, 64'h3fff, 1'b0);
        // Register-register operations on x1 = 5 and x2 = 3.
        expect_write(encode_alu(ALU_ADD, 5, 1, 2), 5, 64'd8, 1'b0);
        expect_write(encode_alu(ALU_SUB, 6, 1, 2), 6, 64'd2, 1'b0);
        expect_write(encode_alu(ALU_AND, 7, 1, 2), 7, 64'd1, 1'b0);
        expect_write(encode_alu(ALU_OR, 8, 1, 2), 8, 64'd7, 1'b0);
        expect_write(encode_alu(ALU_XOR, 9, 1, 2), 9, 64'd6, 1'b0);
        expect_write(encode_alu(ALU_SLT, 10, 3, 1), 10, 64'd1, 1'b0);    // -2 < 5.
        expect_write(encode_alu(ALU_SLT, 11, 1, 3), 11, 64'd0, 1'b0);
        // Doubling x12 from 2^13 up to 2^63 so that the last add overflows.
        expect_write(encode_imm(OP_ADDI, 12, 0, 'h2000), 12, 64'h2000, 1'b0);
        for (int k = 1; k <= 50; k++) begin
            expect_write(encode_alu(ALU_ADD, 12, 12, 12), 12, 64'h2000 << k, k == 50);
        end
        expect_write(encode_imm(OP_ADDI, 15, 0, 1), 15, 64'd1, 1'b0);
        // Most negative minus one wraps to the largest positive value.
        expect_write(encode_alu(ALU_SUB, 13, 12, 15), 13, 64'h7fff_ffff_ffff_ffff, 1'b1);
        expect_write(encode_alu(ALU_ADD, 14, 13, 15), 14, 64'h8000_0000_0000_0000, 1'b1);
        // Store x3 at 0x108, load it back, then alias one memory depth higher.
        expect_write(encode_imm(OP_ADDI, 16, 0, 'h100), 16, 64'h100, 1'b0);
        expect_store(encode_imm(OP_SD, 3, 16, 8));
        expect_write(encode_imm(OP_LD, 17, 16, 8), 17, 64'hffff_ffff_ffff_fffe, 1'b0);
        expect_write(encode_imm(OP_LD, 18, 16, 'h1008), 18, 64'hffff_ffff_ffff_fffe, 1'b0);
        // Register 0.
        expect_write(encode_imm(OP_ADDI, 0, 0, 7), 0, 64'd7, 1'b0);
        expect_write(encode_alu(ALU_ADD, 19, 0, 2), 19, 64'd3, 1'b0);
        // Unknown opcode retires as a no-operation.
        expect_write(32'hf000_0000, 0, 64'd0, 1'b0);
        // Held instruction without the strobe leaves x2 alone.
        expect_idle(encode_imm(OP_ADDI, 2, 0, 'h55));
        expect_write(encode_alu(ALU_ADD, 20, 2, 0), 20, 64'd3, 1'b0);
    endfunction

    // ##############################
    // Step execution and checking
    // ##############################
    task automatic run_step(int idx);
        step_t s;
        int    cycles;
        s           = steps[idx];
        instr       = s.instr;
        instr_valid = s.valid;
        @(posedge cpu_clk);
        #DRIVE_DELAY;
        instr       = '0;
        instr_valid = 1'b0;

        if (s.exp_valid || s.exp_store) begin
            cycles = 0;
            while (!(retire_valid || retire_store) && cycles < TIMEOUT_CYCLES) begin
                @(posedge cpu_clk);
                #DRIVE_DELAY;
                cycles++;
            end
            if (!(retire_valid || retire_store)) begin
                $display("step %0d: no retire pulse within %0d cycles", idx, TIMEOUT_CYCLES);
                timed_out = 1'b1;
                fail_count++;
                return;
            end
        end

        if (retire_valid !== s.exp_valid) begin
            $display("[FAIL] step %0d retire_valid expected %h got %h",
                     idx, s.exp_valid, retire_valid);
            fail_count++;
        end else if (retire_store !== s.exp_store) begin
            $display("[FAIL] step %0d retire_store expected %h got %h",
                     idx, s.exp_store, retire_store);
            fail_count++;
        end else if (!s.exp_store && retire_rd !== s.exp_rd) begin
            $display("[FAIL] step %0d retire_rd expected %h got %h", idx, s.exp_rd, retire_rd);
            fail_count++;
        end else if (!s.exp_store && retire_data !== s.exp_data) begin
            $display("[FAIL] step %0d retire_data expected %h got %h",
                     idx, s.exp_data, retire_data);
            fail_count++;
        end else if (!s.exp_store && retire_overflow !== s.exp_ovf) begin
            $display("[FAIL] step %0d retire_overflow expected %h got %h",
                     idx, s.exp_ovf, retire_overflow);
            fail_count++;
        end else begin
            $display("[PASS] step %0d", idx);
            pass_count++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        build_table();

        repeat (4) @(posedge cpu_clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
            if (timed_out) begin
                break;                     // DUT stopped answering.
            end
        end

        $display("%0d steps run, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
cpu_pkg.sv
control_unit.sv
register_file.sv
alu.sv
data_memory.sv
cpu.sv
tb_cpu.sv

// File: Makefile
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: obj_dir/Vtb_cpu
	@out="$$(./obj_dir/Vtb_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

obj_dir/Vtb_cpu: vlog.f $(SRCS)
	verilator --binary --timing --top-module tb_cpu -f vlog.f

clean:
	rm -rf obj_dir
